// File: bench/gb_mem_bus_tb.sv
`default_nettype none

module gb_mem_bus_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic        clk;
    logic        arst_n;
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        wr;
    logic        rd;
    logic [7:0]  rdata;
    logic        dma_busy;
    logic [15:0] cart_addr;
    logic [7:0]  cart_wdata;
    logic        cart_wr;
    logic        cart_rd;
    logic [7:0]  cart_rdata;
    logic [4:0]  irq;
    logic        int_pending;
    logic [9:0]  int_enable_flags;

    logic [7:0]  shadow [0:65535];              // Random bytes as written, by address
    int unsigned seed_ret;

    gb_mem_bus uut (
        .clk              (clk),
        .arst_n           (arst_n),
        .addr             (addr),
        .wdata            (wdata),
        .wr               (wr),
        .rd               (rd),
        .rdata            (rdata),
        .dma_busy         (dma_busy),
        .cart_addr        (cart_addr),
        .cart_wdata       (cart_wdata),
        .cart_wr          (cart_wr),
        .cart_rd          (cart_rd),
        .cart_rdata       (cart_rdata),
        .irq              (irq),
        .int_pending      (int_pending),
        .int_enable_flags (int_enable_flags)
    );

    // Cartridge model, same-cycle answer
    assign cart_rdata = cart_addr[7:0] ^ cart_addr[15:8];

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                  // 4 ns period
    end

    //////////////////////////////////////////////////////////////////////
    // Checks and bus tasks
    //////////////////////////////////////////////////////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        @(posedge clk);
        addr  <= a;
        wdata <= d;
        wr    <= 1'b1;
        @(posedge clk);
        wr    <= 1'b0;                          // Write landed on this edge
    endtask

    // Data shows up one cycle after rd
    task automatic bus_read(input logic [15:0] a, input logic [7:0] exp);
        @(posedge clk);
        addr <= a;
        rd   <= 1'b1;
        @(posedge clk);
        rd   <= 1'b0;
        @(negedge clk);
        check_value($sformatf("rdata@%h", a), {8'h00, rdata}, {8'h00, exp});
    endtask

    task automatic cart_write(input logic [15:0] a, input logic [7:0] d);
        @(posedge clk);
        addr  <= a;
        wdata <= d;
        wr    <= 1'b1;
        @(negedge clk);                         // Mid-cycle, strobe is up
        check_value("cart_wr", {15'h0000, cart_wr}, 16'h0001);
        check_value("cart_addr", cart_addr, a);
        check_value("cart_wdata", {8'h00, cart_wdata}, {8'h00, d});
        @(posedge clk);
        wr <= 1'b0;
    endtask

    task automatic irq_pulse(input logic [4:0] mask);
        @(posedge clk);
        irq <= mask;
        @(posedge clk);
        irq <= 5'h00;
    endtask

    task automatic check_int(input logic [15:0] flags, input logic [15:0] pend);
        @(negedge clk);
        check_value("int_enable_flags", {6'h00, int_enable_flags}, flags);
        check_value("int_pending", {15'h0000, int_pending}, pend);
    endtask

    // Cart pattern is low byte XOR high byte, key folds in the boot image
    task automatic pattern_sweep(input logic [15:0] start, input logic [15:0] count,
                                 input logic [7:0] key);
        logic [15:0] a;
        logic        to_cart;                   // Plain pattern means the cart answers
        to_cart = (key == 8'h00);
        for (logic [15:0] i = 16'h0000; i < count; i++) begin
            a = start + i;
            @(posedge clk);
            addr <= a;
            rd   <= 1'b1;
            @(negedge clk);                     // Strobe is up
            check_value("cart_rd", {15'h0000, cart_rd}, {15'h0000, to_cart});
            @(posedge clk);
            rd <= 1'b0;
            @(negedge clk);
            check_value($sformatf("rdata@%h", a), {8'h00, rdata},
                        {8'h00, a[7:0] ^ a[15:8] ^ key});
        end
    endtask

    task automatic random_fill(input logic [15:0] start, input logic [15:0] count);
        logic [15:0] a;
        int unsigned rnd;
        for (logic [15:0] i = 16'h0000; i < count; i++) begin
            a         = start + i;
            rnd       = $urandom;
            shadow[a] = rnd[7:0];
            bus_write(a, rnd[7:0]);
        end
    endtask

    task automatic compare_block(input logic [15:0] start, input logic [15:0] src,
                                 input logic [15:0] count);
        for (logic [15:0] i = 16'h0000; i < count; i++) begin
            bus_read(start + i, shadow[src + i]);
        end
    endtask

    task automatic start_dma(input logic [7:0] page);
        bus_write(16'hFF46, page);
        @(negedge clk);
        check_value("dma_busy", {15'h0000, dma_busy}, 16'h0001); // Up one edge later
    endtask

    task automatic wait_dma_idle;
        int cycles;
        cycles = 0;
        while (dma_busy !== 1'b0 && cycles < 400) begin
            @(negedge clk);
            cycles++;
        end
        if (dma_busy !== 1'b0) begin
            abort_run("DMA still busy after 400 cycles");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test file interpreter
    //////////////////////////////////////////////////////////////////////
    initial begin
        int          fd;
        int          n;
        string       line;
        byte         op;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] c;
        seed_ret = $urandom(32'h84c5a264);
        arst_n   = 1'b0;
        addr     = 16'h0000;
        wdata    = 8'h00;
        wr       = 1'b0;
        rd       = 1'b0;
        irq      = 5'h00;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        fd = $fopen("bench/gb_mem_bus_tests.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open bench/gb_mem_bus_tests.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            if (n > 0 && line.len() > 2 && line.getc(0) != "#") begin
                op = line.getc(0);
                n  = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c);
                if (n != 3) begin
                    abort_run($sformatf("bad test line: %s", line));
                end
                case (op)
                    "W": bus_write(a, b[7:0]);
                    "R": bus_read(a, b[7:0]);
                    "T": cart_write(a, b[7:0]);
                    "I": irq_pulse(a[4:0]);
                    "Q": check_int(a, b);
                    "P": pattern_sweep(a, b, c[7:0]);
                    "F": random_fill(a, b);
                    "C": compare_block(a, b, c);
                    "D": start_dma(a[7:0]);
                    "Z": wait_dma_idle();
                    default: abort_run($sformatf("unknown op in line: %s", line));
                endcase
            end
        end
        $fclose(fd);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/gb_mem_bus_tests.txt
# op a b c, values in hex; W write a=b, R read a expect b, T cart write a=b, I irq pulse a
# Q flags=a pending=b, P sweep a count=b key=c, F fill a count=b, C compare a src=b count=c, D dma page a, Z wait dma
Q 0000 0 0
R FF50 00 0
P 0000 100 A5
P 0100 20 0
P A000 10 0
T A123 5C 0
T 2000 01 0
R FF00 00 0
R 8000 00 0
W FF50 01 0
R FF50 01 0
P 0000 100 0
F C000 40 0
C C000 C000 40
C E000 C000 40
W E010 77 0
R C010 77 0
I 05 0 0
R FF0F 05 0
W FFFF 04 0
Q 085 1 0
W FF0F 01 0
Q 081 0 0
I 10 0 0
W FFFF 1F 0
Q 3F1 1 0
W FF0F 00 0
Q 3E0 0 0
F C100 A0 0
D C1 0 0
R C100 FF 0
W C150 5A 0
R FE00 FF 0
Z 0 0 0
R FF46 C1 0
C FE00 C100 A0
C C100 C100 A0

// File: gb_boot.hex
A5 A4 A7 A6 A1 A0 A3 A2 AD AC AF AE A9 A8 AB AA
B5 B4 B7 B6 B1 B0 B3 B2 BD BC BF BE B9 B8 BB BA
85 84 87 86 81 80 83 82 8D 8C 8F 8E 89 88 8B 8A
95 94 97 96 91 90 93 92 9D 9C 9F 9E 99 98 9B 9A
E5 E4 E7 E6 E1 E0 E3 E2 ED EC EF EE E9 E8 EB EA
F5 F4 F7 F6 F1 F0 F3 F2 FD FC FF FE F9 F8 FB FA
C5 C4 C7 C6 C1 C0 C3 C2 CD CC CF CE C9 C8 CB CA
D5 D4 D7 D6 D1 D0 D3 D2 DD DC DF DE D9 D8 DB DA
25 24 27 26 21 20 23 22 2D 2C 2F 2E 29 28 2B 2A
35 34 37 36 31 30 33 32 3D 3C 3F 3E 39 38 3B 3A
05 04 07 06 01 00 03 02 0D 0C 0F 0E 09 08 0B 0A
15 14 17 16 11 10 13 12 1D 1C 1F 1E 19 18 1B 1A
65 64 67 66 61 60 63 62 6D 6C 6F 6E 69 68 6B 6A
75 74 77 76 71 70 73 72 7D 7C 7F 7E 79 78 7B 7A
45 44 47 46 41 40 43 42 4D 4C 4F 4E 49 48 4B 4A
55 54 57 56 51 50 53 52 5D 5C 5F 5E 59 58 5B 5A

// File: gb_mem_bus.f
logic/gb_bus_pkg.sv
logic/gb_addr_decode.sv
logic/gb_work_ram.sv
logic/gb_boot_rom.sv
logic/gb_int_regs.sv
logic/gb_oam_unit.sv
logic/gb_mem_bus.sv
bench/gb_mem_bus_tb.sv

// File: logic/gb_addr_decode.sv
`default_nettype none

module gb_addr_decode (
    input  wire [15:0]                     addr,
    input  wire                            boot_off,
    output logic [gb_bus_pkg::rgn_w-1:0]   region,
    output logic [15:0]                    offset
);

    // First match wins, so the boot overlay sits ahead of the cart range
    always_comb begin
        region = gb_bus_pkg::rgn_junk;
        offset = 16'h0000;                      // Junk reads ignore it
        if (addr[15:8] == 8'h00 && !boot_off) begin
            region = gb_bus_pkg::rgn_boot;
            offset = addr;                      // Upper byte already zero
        end else if (addr <= gb_bus_pkg::cart_rom_end ||
                     (addr >= gb_bus_pkg::cram_start && addr <= gb_bus_pkg::cram_end)) begin
            region = gb_bus_pkg::rgn_cart;
            offset = addr;                      // Cart sees the full address
        end else if (addr >= gb_bus_pkg::wram_start && addr <= gb_bus_pkg::wram_end) begin
            region = gb_bus_pkg::rgn_wram;
            offset = addr - gb_bus_pkg::wram_start;
        end else if (addr >= gb_bus_pkg::echo_start && addr <= gb_bus_pkg::echo_end) begin
            // Echo folds back onto the bottom 7.5 KiB of WRAM
            region = gb_bus_pkg::rgn_wram;
            offset = addr - gb_bus_pkg::echo_start;
        end else if (addr >= gb_bus_pkg::oam_start && addr <= gb_bus_pkg::oam_end) begin
            region = gb_bus_pkg::rgn_oam;
            offset = addr - gb_bus_pkg::oam_start;
        end else if (addr == gb_bus_pkg::mmio_dma) begin
            region = gb_bus_pkg::rgn_dma_reg;
        end else if (addr == gb_bus_pkg::mmio_boot) begin
            region = gb_bus_pkg::rgn_boot_reg;
        end else if (addr == gb_bus_pkg::mmio_if || addr == gb_bus_pkg::mmio_ie) begin
            region = gb_bus_pkg::rgn_int;
            offset = addr;                      // IF and IE told apart by address
        end
    end

    // Both windows must land inside the 8 KiB array
    always_comb begin
        wram_off_in_range: assert final (region != gb_bus_pkg::rgn_wram ||
                                         offset < gb_bus_pkg::wram_words)
            else $error("WRAM offset %h out of range", offset);
    end

endmodule

`default_nettype wire

// File: logic/gb_boot_rom.sv
`default_nettype none

module gb_boot_rom (
    input  wire        clk,
    input  wire        arst_n,
    input  wire [7:0]  offset,
    input  wire        off_we,
    output logic [7:0] rdata,
    output logic       boot_off
);

    // Boot image, 256 bytes
    logic [7:0] rom [0:gb_bus_pkg::boot_words-1];

    initial begin
        $readmemh("gb_boot.hex", rom);
    end

    always_ff @(posedge clk) begin
        rdata <= rom[offset];                   // Same latency as WRAM
    end

    // Sticky off latch, any write to FF50 unmaps the ROM for good
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            boot_off <= 1'b0;
        end else if (off_we) begin
            boot_off <= 1'b1;
        end
    end

    // Once unmapped, the ROM stays gone until the next reset
    boot_off_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        $past(boot_off) |-> boot_off)
        else $error("boot_off fell without reset");

endmodule

`default_nettype wire

// File: logic/gb_bus_pkg.sv
`default_nettype none

package gb_bus_pkg;

    //////////////////////////////////////////////////////////////////////
    // Region codes out of the address decoder
    //////////////////////////////////////////////////////////////////////
    localparam int unsigned rgn_w = 3;

    localparam logic [rgn_w-1:0] rgn_junk     = 3'd0; // Unmapped or not modeled, reads 00
    localparam logic [rgn_w-1:0] rgn_boot     = 3'd1; // Boot ROM overlay
    localparam logic [rgn_w-1:0] rgn_boot_reg = 3'd2; // FF50 off latch
    localparam logic [rgn_w-1:0] rgn_wram     = 3'd3; // WRAM and its echo
    localparam logic [rgn_w-1:0] rgn_cart     = 3'd4; // Cart ROM and cart RAM
    localparam logic [rgn_w-1:0] rgn_oam      = 3'd5; // Sprite attribute table
    localparam logic [rgn_w-1:0] rgn_dma_reg  = 3'd6; // FF46
    localparam logic [rgn_w-1:0] rgn_int      = 3'd7; // IF and IE

    //////////////////////////////////////////////////////////////////////
    // Memory map
    //////////////////////////////////////////////////////////////////////
    localparam logic [15:0] cart_rom_end = 16'h7FFF;
    localparam logic [15:0] cram_start   = 16'hA000; // External cart RAM
    localparam logic [15:0] cram_end     = 16'hBFFF;
    localparam logic [15:0] wram_start   = 16'hC000;
    localparam logic [15:0] wram_end     = 16'hDFFF;
    localparam logic [15:0] echo_start   = 16'hE000; // Mirror of C000 onwards
    localparam logic [15:0] echo_end     = 16'hFDFF;
    localparam logic [15:0] oam_start    = 16'hFE00;
    localparam logic [15:0] oam_end      = 16'hFE9F;

    // Single byte registers
    localparam logic [15:0] mmio_if   = 16'hFF0F;
    localparam logic [15:0] mmio_dma  = 16'hFF46;
    localparam logic [15:0] mmio_boot = 16'hFF50;
    localparam logic [15:0] mmio_ie   = 16'hFFFF;

    // Storage sizes
    localparam int unsigned wram_words = 8192;
    localparam int unsigned wram_aw    = 13;
    localparam int unsigned oam_words  = 160;  // 40 sprites of 4 bytes
    localparam int unsigned oam_aw     = 8;
    localparam int unsigned boot_words = 256;
    localparam int unsigned int_count  = 5;    // VBlank, STAT, timer, serial, joypad

endpackage

`default_nettype wire

// File: logic/gb_int_regs.sv
`default_nettype none

module gb_int_regs (
    input  wire                                 clk,
    input  wire                                 arst_n,
    input  wire [gb_bus_pkg::int_count-1:0]     irq,
    input  wire                                 sel_ie,
    input  wire                                 sel_if,
    input  wire                                 we,
    input  wire [7:0]                           wdata,
    output logic [7:0]                          rdata,
    output logic                                int_pending,
    output logic [2*gb_bus_pkg::int_count-1:0]  int_enable_flags
);

    logic [gb_bus_pkg::int_count-1:0] ie_q; // Enable mask
    logic [gb_bus_pkg::int_count-1:0] if_q; // Request flags

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ie_q <= '0;
            if_q <= '0;
        end else begin
            if (we && sel_ie) begin
                ie_q <= wdata[gb_bus_pkg::int_count-1:0];
            end
            // Bus write wins over a request arriving in the same cycle
            if (we && sel_if) begin
                if_q <= wdata[gb_bus_pkg::int_count-1:0];
            end else begin
                if_q <= if_q | irq;             // Requests accumulate
            end
        end
    end

    // Upper three bits read as zero
    always_comb begin
        rdata = 8'h00;
        if (sel_ie) begin
            rdata[gb_bus_pkg::int_count-1:0] = ie_q;
        end else if (sel_if) begin
            rdata[gb_bus_pkg::int_count-1:0] = if_q;
        end
    end

    assign int_pending      = |(ie_q & if_q);   // Level, straight from the flops
    assign int_enable_flags = {ie_q, if_q};

endmodule

`default_nettype wire

// File: logic/gb_mem_bus.sv
`default_nettype none

module gb_mem_bus (
    input  wire                                 clk,
    input  wire                                 arst_n,
    input  wire [15:0]                          addr,
    input  wire [7:0]                           wdata,
    input  wire                                 wr,
    input  wire                                 rd,
    output logic [7:0]                          rdata,
    output logic                                dma_busy,
    output logic [15:0]                         cart_addr,
    output logic [7:0]                          cart_wdata,
    output logic                                cart_wr,
    output logic                                cart_rd,
    input  wire [7:0]                           cart_rdata,
    input  wire [gb_bus_pkg::int_count-1:0]     irq,
    output logic                                int_pending,
    output logic [2*gb_bus_pkg::int_count-1:0]  int_enable_flags
);

    logic [15:0]                  dma_addr;
    logic                         dma_rd;
    logic [15:0]                  bus_addr;     // Address of whoever owns the bus
    logic                         bus_wr;
    logic                         bus_rd;
    logic [gb_bus_pkg::rgn_w-1:0] region;
    logic [15:0]                  offset;
    logic                         boot_off;
    logic [7:0]                   wram_rdata;
    logic [7:0]                   boot_rdata;
    logic [7:0]                   oam_rdata;
    logic [7:0]                   int_rdata;
    logic [7:0]                   comb_word;    // Sources with no read register
    logic [7:0]                   comb_q;
    logic [7:0]                   bus_rdata;
    logic [gb_bus_pkg::rgn_w-1:0] rd_rgn_q;     // Region of last cycle's access
    logic                         busy_rd_q;    // Master read hit a DMA cycle

    //////////////////////////////////////////////////////////////////////
    // Ownership and decode
    //////////////////////////////////////////////////////////////////////
    assign bus_addr = dma_busy ? dma_addr : addr;
    assign bus_wr   = wr & ~dma_busy;           // DMA never writes the bus
    assign bus_rd   = dma_busy ? dma_rd : rd;

    gb_addr_decode u_decode (
        .addr     (bus_addr),
        .boot_off (boot_off),
        .region   (region),
        .offset   (offset)
    );

    gb_work_ram u_wram (
        .clk    (clk),
        .we     (bus_wr && region == gb_bus_pkg::rgn_wram),
        .offset (offset[gb_bus_pkg::wram_aw-1:0]),
        .wdata  (wdata),
        .rdata  (wram_rdata)
    );

    // FF50, IF and IE stay open to the master while DMA runs
    gb_boot_rom u_boot (
        .clk      (clk),
        .arst_n   (arst_n),
        .offset   (offset[7:0]),
        .off_we   (wr && addr == gb_bus_pkg::mmio_boot),
        .rdata    (boot_rdata),
        .boot_off (boot_off)
    );

    gb_int_regs u_int (
        .clk              (clk),
        .arst_n           (arst_n),
        .irq              (irq),
        .sel_ie           (addr == gb_bus_pkg::mmio_ie),
        .sel_if           (addr == gb_bus_pkg::mmio_if),
        .we               (wr),
        .wdata            (wdata),
        .rdata            (int_rdata),
        .int_pending      (int_pending),
        .int_enable_flags (int_enable_flags)
    );

    gb_oam_unit u_oam (
        .clk       (clk),
        .arst_n    (arst_n),
        .sel_dma   (region == gb_bus_pkg::rgn_dma_reg),
        .sel_oam   (region == gb_bus_pkg::rgn_oam),
        .we        (bus_wr),
        .offset    (offset[gb_bus_pkg::oam_aw-1:0]),
        .wdata     (wdata),
        .rdata     (oam_rdata),
        .dma_busy  (dma_busy),
        .dma_addr  (dma_addr),
        .dma_rd    (dma_rd),
        .dma_rdata (bus_rdata)                  // DMA shares the read path
    );

    // Cartridge answers in the same cycle
    assign cart_addr  = bus_addr;
    assign cart_wdata = wdata;
    assign cart_wr    = bus_wr & (region == gb_bus_pkg::rgn_cart);
    assign cart_rd    = bus_rd & (region == gb_bus_pkg::rgn_cart);

    //////////////////////////////////////////////////////////////////////
    // Read multiplexer, one cycle behind the access
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (region)
            gb_bus_pkg::rgn_cart:     comb_word = cart_rdata;
            gb_bus_pkg::rgn_int:      comb_word = int_rdata;
            gb_bus_pkg::rgn_boot_reg: comb_word = {7'h00, boot_off};
            default:                  comb_word = 8'h00;  // Junk space
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_rgn_q  <= gb_bus_pkg::rgn_junk;
            busy_rd_q <= 1'b0;
        end else begin
            rd_rgn_q  <= region;
            busy_rd_q <= rd & dma_busy;
        end
    end

    always_ff @(posedge clk) begin
        comb_q <= comb_word;                    // Matches the RAM latency
    end

    always_comb begin
        case (rd_rgn_q)
            gb_bus_pkg::rgn_wram:    bus_rdata = wram_rdata;
            gb_bus_pkg::rgn_boot:    bus_rdata = boot_rdata;
            gb_bus_pkg::rgn_oam,
            gb_bus_pkg::rgn_dma_reg: bus_rdata = oam_rdata;
            default:                 bus_rdata = comb_q;
        endcase
    end

    assign rdata = busy_rd_q ? 8'hFF : bus_rdata; // Master locked out by DMA

endmodule

`default_nettype wire

// File: logic/gb_oam_unit.sv
`default_nettype none

module gb_oam_unit (
    input  wire                            clk,
    input  wire                            arst_n,
    input  wire                            sel_dma,
    input  wire                            sel_oam,
    input  wire                            we,
    input  wire [gb_bus_pkg::oam_aw-1:0]   offset,
    input  wire [7:0]                      wdata,
    output logic [7:0]                     rdata,
    output logic                           dma_busy,
    output logic [15:0]                    dma_addr,
    output logic                           dma_rd,
    input  wire [7:0]                      dma_rdata
);

    logic [7:0] oam [0:gb_bus_pkg::oam_words-1];

    logic                          dma_start;
    logic [7:0]                    src_page;    // High byte of the source
    logic [gb_bus_pkg::oam_aw-1:0] cnt;         // Byte being read
    logic                          rd_done;     // All 160 reads issued
    logic                          wr_pend;     // Read data arrives this cycle
    logic [gb_bus_pkg::oam_aw-1:0] wr_idx;      // Where that data goes

    assign dma_start = sel_dma & we;

    //////////////////////////////////////////////////////////////////////
    // DMA engine
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dma_busy <= 1'b0;
            src_page <= 8'h00;
            cnt      <= '0;
            rd_done  <= 1'b0;
            wr_pend  <= 1'b0;
        end else if (dma_start) begin
            dma_busy <= 1'b1;                   // Busy from the next edge
            src_page <= wdata;
            cnt      <= '0;
            rd_done  <= 1'b0;
            wr_pend  <= 1'b0;
        end else if (dma_busy) begin
            wr_pend <= dma_rd;                  // Read now, write next cycle
            if (dma_rd) begin
                if (cnt == gb_bus_pkg::oam_aw'(gb_bus_pkg::oam_words - 1)) begin
                    rd_done <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
            if (rd_done && wr_pend) begin
                dma_busy <= 1'b0;               // Drops after byte 159 lands
            end
        end
    end

    always_ff @(posedge clk) begin
        wr_idx <= cnt;                          // Follows the read by one cycle
    end

    assign dma_rd   = dma_busy & ~rd_done;
    assign dma_addr = {src_page, cnt};          // page*256 + i

    //////////////////////////////////////////////////////////////////////
    // OAM storage
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (wr_pend) begin
            oam[wr_idx] <= dma_rdata;
        end else if (sel_oam && we) begin
            oam[offset] <= wdata;               // Master path, idle only
        end
        if (sel_dma) begin
            rdata <= src_page;                  // FF46 reads back the page
        end else if (sel_oam) begin
            rdata <= oam[offset];
        end else begin
            rdata <= 8'h00;
        end
    end

    // Read index never walks off the end of the table during a copy
    dma_cnt_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        dma_busy |-> (cnt < gb_bus_pkg::oam_words))
        else $error("DMA counter %0d past OAM", cnt);

endmodule

`default_nettype wire

// File: logic/gb_work_ram.sv
`default_nettype none

module gb_work_ram (
    input  wire                            clk,
    input  wire                            we,
    input  wire [gb_bus_pkg::wram_aw-1:0]  offset,
    input  wire [7:0]                      wdata,
    output logic [7:0]                     rdata
);

    // 8 KiB block RAM, one port
    logic [7:0] mem [0:gb_bus_pkg::wram_words-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[offset] <= wdata;
        end
        rdata <= mem[offset];                   // Old data on a same-cycle write
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run gb_mem_bus_tb with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f gb_mem_bus.f --top-module gb_mem_bus_tb -o gb_mem_bus_sim \
    && ./obj_dir/gb_mem_bus_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }
